// File: verilog/temp_pkg.sv
`default_nettype none

package temp_pkg;

    localparam int N_SENSORS     = 4;
    localparam int TEMP_BITS     = 13;
    localparam int FRAME_BITS    = 14;   // 13 temperature bits + done flag
    localparam int SCK_PHASE     = 6;    // MCLK cycles per sck half period
    localparam int PERIOD_CYCLES = 256;  // must exceed the 171-cycle read
    localparam int STALE_BITS    = 8;

    localparam int PERIOD_W = $clog2(PERIOD_CYCLES);
    localparam int PHASE_W  = $clog2(SCK_PHASE + 1);
    localparam int BIT_W    = $clog2(FRAME_BITS + 1);

    // most negative reading, used when no channel has reported yet
    localparam logic signed [TEMP_BITS-1:0] TEMP_MIN = {1'b1, {(TEMP_BITS-1){1'b0}}};

    // serial order is MSB first, so temp leads and done is the last bit
    typedef struct packed {
        logic signed [TEMP_BITS-1:0] temp;
        logic                        done;  // conversion complete
    } temp_frame_t;

    typedef struct packed {
        logic signed [TEMP_BITS-1:0] temp;   // last good reading
        logic [STALE_BITS-1:0]       stale;  // frames with done clear, saturating
        logic                        seen;   // at least one good frame
    } chan_status_t;

endpackage

`default_nettype wire

// File: verilog/acq_scheduler.sv
`timescale 1ns/100ps
`default_nettype none

module acq_scheduler (
    input  logic MCLK,
    input  logic arst_n,
    input  logic enable,
    output logic load_n
);

    logic [temp_pkg::PERIOD_W-1:0] period_cnt;
    logic                          terminal;

    assign terminal = (period_cnt == temp_pkg::PERIOD_W'(temp_pkg::PERIOD_CYCLES - 1));

    always_ff @(posedge MCLK or negedge arst_n) begin
        if (!arst_n) begin
            period_cnt <= '0;
            load_n     <= 1'b1;
        end else if (!enable) begin
            period_cnt <= '0;  // restart so the first strobe is a full period away
            load_n     <= 1'b1;
        end else begin
            load_n <= ~terminal;  // one-cycle low pulse
            if (terminal) begin
                period_cnt <= '0;
            end else begin
                period_cnt <= period_cnt + 1'b1;
            end
        end
    end

    // strobe is a single cycle, never a level
    a_load_pulse: assert property (
        @(posedge MCLK) disable iff (!arst_n)
        !load_n |=> load_n
    );

endmodule

`default_nettype wire

// File: verilog/tc77_reader.sv
`timescale 1ns/100ps
`default_nettype none

module tc77_reader (
    input  logic                  MCLK,
    input  logic                  arst_n,
    input  logic                  load_n,
    input  logic                  sio,
    output logic                  cs_n,
    output logic                  sck,
    output temp_pkg::temp_frame_t frame,
    output logic                  complete_n
);

    typedef enum logic [1:0] {
        st_idle,
        st_select,
        st_phase,
        st_finish
    } state_t;

    state_t                       state;
    logic [temp_pkg::PHASE_W-1:0] phase_cnt;  // 1..SCK_PHASE within a half period
    logic [temp_pkg::BIT_W-1:0]   bit_cnt;    // bits sampled so far
    logic                         half_end;
    logic                         sck_rise;

    assign half_end = (state == st_phase) &&
                      (phase_cnt == temp_pkg::PHASE_W'(temp_pkg::SCK_PHASE));
    assign sck_rise = half_end && !sck;

    always_ff @(posedge MCLK or negedge arst_n) begin
        if (!arst_n) begin
            state      <= st_idle;
            cs_n       <= 1'b1;
            sck        <= 1'b0;
            complete_n <= 1'b1;
            phase_cnt  <= '0;
            bit_cnt    <= '0;
        end else begin
            case (state)
                st_idle: begin
                    complete_n <= 1'b1;
                    cs_n       <= 1'b1;
                    sck        <= 1'b0;
                    if (!load_n) begin
                        state <= st_select;
                    end
                end
                st_select: begin
                    cs_n      <= 1'b0;  // first bit starts here
                    sck       <= 1'b0;
                    phase_cnt <= temp_pkg::PHASE_W'(1);
                    bit_cnt   <= '0;
                    state     <= st_phase;
                end
                st_phase: begin
                    if (half_end) begin
                        phase_cnt <= temp_pkg::PHASE_W'(1);
                        sck       <= ~sck;
                        if (sck_rise) begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end else if (bit_cnt == temp_pkg::BIT_W'(temp_pkg::FRAME_BITS)) begin
                            cs_n  <= 1'b1;  // release with the last falling sck
                            state <= st_finish;
                        end
                    end else begin
                        phase_cnt <= phase_cnt + 1'b1;
                    end
                end
                st_finish: begin
                    complete_n <= 1'b0;
                    state      <= st_idle;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // sample on the rising sck since the sensor changed sio on the falling one
    always_ff @(posedge MCLK) begin
        if (sck_rise) begin
            frame <= {frame[temp_pkg::FRAME_BITS-2:0], sio};
        end
    end

    a_sck_idle_low: assert property (
        @(posedge MCLK) disable iff (!arst_n)
        cs_n |-> !sck
    );

    // frame handed over only after the sensor is deselected
    a_complete_deselected: assert property (
        @(posedge MCLK) disable iff (!arst_n)
        !complete_n |-> cs_n
    );

endmodule

`default_nettype wire

// File: verilog/sample_collector.sv
`timescale 1ns/100ps
`default_nettype none

module sample_collector (
    input  logic                                                  MCLK,
    input  logic                                                  arst_n,
    input  logic [temp_pkg::N_SENSORS-1:0]                        complete_n,
    input  temp_pkg::temp_frame_t [temp_pkg::N_SENSORS-1:0]       frames,
    input  logic signed [temp_pkg::TEMP_BITS-1:0]                 threshold,
    output temp_pkg::chan_status_t [temp_pkg::N_SENSORS-1:0]      status,
    output logic signed [temp_pkg::TEMP_BITS-1:0]                 max_temp,
    output logic                                                  frame_done,
    output logic                                                  alarm
);

    logic signed [temp_pkg::TEMP_BITS-1:0] max_comb;

    // signed max over channels that have reported a good frame
    always_comb begin
        max_comb = temp_pkg::TEMP_MIN;
        for (int i = 0; i < temp_pkg::N_SENSORS; i++) begin
            if (status[i].seen && (status[i].temp > max_comb)) begin
                max_comb = status[i].temp;
            end
        end
    end

    always_ff @(posedge MCLK or negedge arst_n) begin
        if (!arst_n) begin
            status     <= '0;
            max_temp   <= temp_pkg::TEMP_MIN;
            frame_done <= 1'b0;
            alarm      <= 1'b0;
        end else begin
            frame_done <= (complete_n == '0);  // readers run in lockstep
            max_temp   <= max_comb;
            alarm      <= (max_comb > threshold);
            for (int i = 0; i < temp_pkg::N_SENSORS; i++) begin
                if (!complete_n[i]) begin
                    if (frames[i].done) begin
                        status[i].temp <= frames[i].temp;
                        status[i].seen <= 1'b1;
                    end else if (status[i].stale != '1) begin
                        status[i].stale <= status[i].stale + 1'b1;  // saturate at max
                    end
                end
            end
        end
    end

    // one shared load strobe keeps every reader on the same cycle
    a_complete_lockstep: assert property (
        @(posedge MCLK) disable iff (!arst_n)
        (complete_n == '0) || (complete_n == '1)
    );

endmodule

`default_nettype wire

// File: verilog/temp_monitor_top.sv
`timescale 1ns/100ps
`default_nettype none

module temp_monitor_top (
    input  logic                                             MCLK,
    input  logic                                             arst_n,
    input  logic                                             enable,
    input  logic signed [temp_pkg::TEMP_BITS-1:0]            threshold,
    input  logic [temp_pkg::N_SENSORS-1:0]                   sio,
    output logic [temp_pkg::N_SENSORS-1:0]                   cs_n,
    output logic [temp_pkg::N_SENSORS-1:0]                   sck,
    output temp_pkg::chan_status_t [temp_pkg::N_SENSORS-1:0] status,
    output logic signed [temp_pkg::TEMP_BITS-1:0]            max_temp,
    output logic                                             frame_done,
    output logic                                             alarm
);

    logic                                              load_n;
    logic [temp_pkg::N_SENSORS-1:0]                    complete_n;
    temp_pkg::temp_frame_t [temp_pkg::N_SENSORS-1:0]   frames;

    acq_scheduler i_scheduler (
        .MCLK   (MCLK),
        .arst_n (arst_n),
        .enable (enable),
        .load_n (load_n)
    );

    // one reader per sensor, all started by the common strobe
    for (genvar i = 0; i < temp_pkg::N_SENSORS; i++) begin : g_reader
        tc77_reader i_reader (
            .MCLK       (MCLK),
            .arst_n     (arst_n),
            .load_n     (load_n),
            .sio        (sio[i]),
            .cs_n       (cs_n[i]),
            .sck        (sck[i]),
            .frame      (frames[i]),
            .complete_n (complete_n[i])
        );
    end

    sample_collector i_collector (
        .MCLK       (MCLK),
        .arst_n     (arst_n),
        .complete_n (complete_n),
        .frames     (frames),
        .threshold  (threshold),
        .status     (status),
        .max_temp   (max_temp),
        .frame_done (frame_done),
        .alarm      (alarm)
    );

endmodule

`default_nettype wire

// File: testbench/tc77_sensor_model.sv
`timescale 1ns/100ps
`default_nettype none

module tc77_sensor_model (
    input  logic                  cs_n,
    input  logic                  sck,
    input  temp_pkg::temp_frame_t frame,
    output logic                  sio
);

    logic [temp_pkg::FRAME_BITS-1:0] shift_reg = '0;

    assign sio = shift_reg[temp_pkg::FRAME_BITS-1];  // MSB goes out first

    always begin
        @(negedge cs_n);
        shift_reg = frame;  // conversion result latched on select
        while (!cs_n) begin
            @(negedge sck or posedge cs_n);
            if (!cs_n) begin
                // next bit is presented on the falling sck
                shift_reg = {shift_reg[temp_pkg::FRAME_BITS-2:0], 1'b0};
            end
        end
    end

endmodule

`default_nettype wire

// File: testbench/tb_temp_monitor.sv
`timescale 1ns/100ps
`default_nettype none

module tb_temp_monitor;

    localparam int N = temp_pkg::N_SENSORS;
    localparam int TIMEOUT_CYCLES = 40 * temp_pkg::PERIOD_CYCLES + 1000;  // 30 frames + idle gap

    logic                                  MCLK = 1'b0;
    logic                                  arst_n;
    logic                                  enable;
    logic signed [temp_pkg::TEMP_BITS-1:0] threshold;
    logic [N-1:0]                          sio;
    logic [N-1:0]                          cs_n;
    logic [N-1:0]                          sck;
    temp_pkg::chan_status_t [N-1:0]        status;
    logic signed [temp_pkg::TEMP_BITS-1:0] max_temp;
    logic                                  frame_done;
    logic                                  alarm;

    temp_pkg::temp_frame_t  frame_in   [N];  // frame each sensor sends next
    temp_pkg::chan_status_t ref_status [N];
    logic [31:0]  rng_state = 32'h678574c8;
    logic [N-1:0] prev_cs_n = '1;
    logic [N-1:0] prev_sck  = '0;
    int           sck_rises [N];
    bit           expect_idle = 1'b0;  // no read may start
    int           cycle_cnt   = 0;
    int           n_checks    = 0;
    int           n_value_err = 0;
    int           n_other_err = 0;

    always #50 MCLK = ~MCLK;

    temp_monitor_top i_dut (
        .MCLK       (MCLK),
        .arst_n     (arst_n),
        .enable     (enable),
        .threshold  (threshold),
        .sio        (sio),
        .cs_n       (cs_n),
        .sck        (sck),
        .status     (status),
        .max_temp   (max_temp),
        .frame_done (frame_done),
        .alarm      (alarm)
    );

    for (genvar i = 0; i < N; i++) begin : g_sensor
        tc77_sensor_model i_sensor (
            .cs_n  (cs_n[i]),
            .sck   (sck[i]),
            .frame (frame_in[i]),
            .sio   (sio[i])
        );
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    task automatic check_value(input string name, input int expected, input int actual);
        n_checks++;
        assert (expected == actual) else begin
            n_value_err++;
            $display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic load_next_frames();
        logic [31:0] r;
        for (int i = 0; i < N; i++) begin
            r = next_rand();
            frame_in[i].temp = r[12:0];
            frame_in[i].done = (r[21:20] != 2'b00);  // set 3 times out of 4
        end
    endtask

    // good frame stores the reading and bad frame bumps the stale count
    task automatic update_reference();
        for (int i = 0; i < N; i++) begin
            if (frame_in[i].done) begin
                ref_status[i].temp = frame_in[i].temp;
                ref_status[i].seen = 1'b1;
            end else if (ref_status[i].stale != 8'hff) begin
                ref_status[i].stale = ref_status[i].stale + 8'd1;
            end
        end
    endtask

    task automatic check_status();
        for (int i = 0; i < N; i++) begin
            check_value($sformatf("stored temp ch%0d", i), ref_status[i].temp, status[i].temp);
            check_value($sformatf("stale count ch%0d", i), ref_status[i].stale, status[i].stale);
            check_value($sformatf("seen flag ch%0d", i), ref_status[i].seen, status[i].seen);
        end
    endtask

    task automatic check_max_alarm();
        logic signed [temp_pkg::TEMP_BITS-1:0] exp_max;
        exp_max = {1'b1, {(temp_pkg::TEMP_BITS-1){1'b0}}};  // floor when nothing seen
        for (int i = 0; i < N; i++) begin
            if (ref_status[i].seen && (ref_status[i].temp > exp_max)) begin
                exp_max = ref_status[i].temp;
            end
        end
        check_value("max_temp", exp_max, max_temp);
        check_value("alarm", int'(exp_max > threshold), alarm);
    endtask

    task automatic check_reset_idle(input int cycles);
        repeat (cycles) begin
            @(negedge MCLK);
            check_value("cs_n after reset", (1 << N) - 1, cs_n);
            check_value("sck after reset", 0, sck);
            check_value("alarm after reset", 0, alarm);
            check_value("frame_done after reset", 0, frame_done);
        end
    endtask

    task automatic run_frames(input int count);
        logic [31:0] r;
        repeat (count) begin
            @(negedge MCLK);
            while (!frame_done) begin
                @(negedge MCLK);
            end
            update_reference();
            check_status();
            load_next_frames();
            r = next_rand();
            threshold = {1'b0, r[11:0]};  // new limit seen by the next alarm update
            @(negedge MCLK);
            check_max_alarm();
        end
    endtask

    // 14 sck rises per select and no select while disabled
    always @(negedge MCLK) begin
        if (arst_n) begin
            for (int i = 0; i < N; i++) begin
                if (prev_cs_n[i] && !cs_n[i]) begin
                    sck_rises[i] = 0;
                    n_checks++;
                    assert (!expect_idle) else begin
                        n_other_err++;
                        $display("channel %0d started a read while acquisition was disabled", i);
                    end
                end else if (!cs_n[i] && !prev_sck[i] && sck[i]) begin
                    sck_rises[i]++;
                end else if (!prev_cs_n[i] && cs_n[i]) begin
                    check_value($sformatf("sck rises ch%0d", i), temp_pkg::FRAME_BITS,
                                sck_rises[i]);
                end
            end
        end
        prev_cs_n = cs_n;
        prev_sck  = sck;
    end

    always @(posedge MCLK) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: run still busy after %0d clock cycles", TIMEOUT_CYCLES);
            $display("checks %0d, value errors %0d, other errors %0d",
                     n_checks, n_value_err, n_other_err + 1);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        arst_n    = 1'b0;
        enable    = 1'b0;
        threshold = '0;
        for (int i = 0; i < N; i++) begin
            ref_status[i] = '0;
            sck_rises[i]  = 0;
        end
        load_next_frames();
        repeat (5) @(negedge MCLK);
        arst_n = 1'b1;
        check_reset_idle(20);
        enable = 1'b1;
        run_frames(18);
        enable      = 1'b0;  // off between reads with nothing in flight
        expect_idle = 1'b1;
        repeat (3 * temp_pkg::PERIOD_CYCLES) @(negedge MCLK);
        enable      = 1'b1;
        expect_idle = 1'b0;
        run_frames(12);
        $display("checks %0d, value errors %0d, other errors %0d",
                 n_checks, n_value_err, n_other_err);
        if ((n_value_err + n_other_err) == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
verilog/temp_pkg.sv
verilog/acq_scheduler.sv
verilog/tc77_reader.sv
verilog/sample_collector.sv
verilog/temp_monitor_top.sv
testbench/tc77_sensor_model.sv
testbench/tb_temp_monitor.sv

// File: run_sim.sh
#!/bin/sh
# build the temperature monitor testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f all.f --top-module tb_temp_monitor -o sim_temp_monitor

sim_status=0
./obj_dir/sim_temp_monitor > sim.log 2>&1 || sim_status=$?
cat sim.log

if grep -q "Simulation failed" sim.log; then
    echo "run_sim: testbench reported failure"
    exit 1
fi
if [ "$sim_status" -ne 0 ] || ! grep -q "Simulation passed" sim.log; then
    echo "run_sim: simulation ended without a result"
    exit 1
fi
